// File: rtl/btb_defines.svh
`ifndef BTB_DEFINES_SVH
`define BTB_DEFINES_SVH

// table depth of two or more entries
`define BTB_ENTRIES 8

// width of branch and target addresses
`define BTB_ADDR_WIDTH 16

`endif

// File: rtl/btb_pkg.sv
`include "btb_defines.svh"

package btb_pkg;

  // entry index width
  localparam int btb_idx_w = (`BTB_ENTRIES > 1) ? $clog2(`BTB_ENTRIES) : 1;

  // two-bit direction counter whose upper half predicts taken
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } pred_state_t;

  // one resolved branch from the resolve stage
  typedef struct packed {
    logic [`BTB_ADDR_WIDTH-1:0] key;
    logic [`BTB_ADDR_WIDTH-1:0] target;
    logic                       taken;
  } btb_update_t;

  // lookup result back to fetch
  typedef struct packed {
    logic                       hit;
    logic [`BTB_ADDR_WIDTH-1:0] target;
  } btb_lookup_t;

endpackage

// File: rtl/btb_entry.sv
`timescale 1ns/100ps

`include "btb_defines.svh"

module btb_entry (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`BTB_ADDR_WIDTH-1:0] lookup_key,
  input  btb_pkg::btb_update_t       update,
  input  logic                       refresh_en,
  input  logic                       replace_en,
  output logic                       key_match,
  output logic                       lookup_match,
  output logic [`BTB_ADDR_WIDTH-1:0] target
);

  import btb_pkg::*;

  logic                       occupied;
  logic [`BTB_ADDR_WIDTH-1:0] key_q;
  logic [`BTB_ADDR_WIDTH-1:0] target_q;
  pred_state_t                state_q;
  pred_state_t                state_step;
  logic                       predict_taken;

  // saturating step toward the resolved outcome
  always_comb begin
    state_step = state_q;
    case (state_q)
      strong_not_taken: begin
        state_step = update.taken ? weak_not_taken : strong_not_taken;
      end
      weak_not_taken: begin
        state_step = update.taken ? weak_taken : strong_not_taken;
      end
      weak_taken: begin
        state_step = update.taken ? strong_taken : weak_not_taken;
      end
      strong_taken: begin
        state_step = update.taken ? strong_taken : weak_taken;
      end
      default: begin
        state_step = strong_not_taken;
      end
    endcase
  end

  // occupied flag and counter
  always_ff @(posedge clk) begin
    if (reset) begin
      occupied <= 1'b0;
      state_q  <= strong_not_taken;
    end else if (replace_en) begin
      occupied <= 1'b1;
      state_q  <= update.taken ? strong_taken : strong_not_taken;
    end else if (refresh_en) begin
      state_q <= state_step;
    end
  end

  // key and target payload
  always_ff @(posedge clk) begin
    if (replace_en) begin
      key_q <= update.key;
    end
    // a not-taken refresh keeps the old target
    if (replace_en || (refresh_en && update.taken)) begin
      target_q <= update.target;
    end
  end

  assign predict_taken = (state_q == weak_taken) || (state_q == strong_taken);

  // update side compare for the allocator
  assign key_match = occupied && (update.key == key_q);

  // fetch side compare hits only when predicted taken
  assign lookup_match = occupied && (lookup_key == key_q) && predict_taken;

  assign target = target_q;

endmodule

// File: rtl/btb_alloc.sv
`timescale 1ns/100ps

`include "btb_defines.svh"

module btb_alloc (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    update_valid,
  input  logic [`BTB_ENTRIES-1:0] key_match,
  output logic [`BTB_ENTRIES-1:0] refresh_en,
  output logic [`BTB_ENTRIES-1:0] replace_en
);

  import btb_pkg::*;

  logic [btb_idx_w-1:0]    victim_q;
  logic [btb_idx_w-1:0]    victim_next;
  logic [`BTB_ENTRIES-1:0] victim_onehot;
  logic                    any_match;
  logic                    do_replace;

  assign any_match  = |key_match;
  assign do_replace = update_valid && !any_match;

  // one-hot of the victim pointer
  always_comb begin
    victim_onehot           = '0;
    victim_onehot[victim_q] = 1'b1;
  end

  // a known key refreshes in place and a new key replaces the victim
  always_comb begin
    refresh_en = '0;
    replace_en = '0;
    if (update_valid) begin
      if (any_match) begin
        refresh_en = key_match;
      end else begin
        replace_en = victim_onehot;
      end
    end
  end

  // explicit wrap at the table depth
  always_comb begin
    if (victim_q == btb_idx_w'(`BTB_ENTRIES - 1)) begin
      victim_next = '0;
    end else begin
      victim_next = victim_q + 1'b1;
    end
  end

  // pointer only moves on a replace
  always_ff @(posedge clk) begin
    if (reset) begin
      victim_q <= '0;
    end else if (do_replace) begin
      victim_q <= victim_next;
    end
  end

endmodule

// File: rtl/btb_select.sv
`timescale 1ns/100ps

`include "btb_defines.svh"

module btb_select (
  input  logic [`BTB_ENTRIES-1:0]                 lookup_match,
  input  logic [`BTB_ENTRIES*`BTB_ADDR_WIDTH-1:0] targets,
  output btb_pkg::btb_lookup_t                    lookup
);

  import btb_pkg::*;

  logic [btb_idx_w-1:0]       match_idx;
  logic [`BTB_ADDR_WIDTH-1:0] match_target;
  logic                       any_hit;

  // priority encode with the lowest index winning
  always_comb begin
    match_idx = '0;
    for (int i = `BTB_ENTRIES - 1; i >= 0; i--) begin
      if (lookup_match[i]) begin
        match_idx = btb_idx_w'(i);
      end
    end
  end

  assign any_hit = |lookup_match;

  // target of the selected entry
  assign match_target = targets[match_idx*`BTB_ADDR_WIDTH +: `BTB_ADDR_WIDTH];

  // zero target on a miss
  always_comb begin
    lookup.hit = any_hit;
    if (any_hit) begin
      lookup.target = match_target;
    end else begin
      lookup.target = '0;
    end
  end

endmodule

// File: rtl/btb_top.sv
`timescale 1ns/100ps

`include "btb_defines.svh"

module btb_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`BTB_ADDR_WIDTH-1:0] lookup_key,
  input  logic                       update_valid,
  input  btb_pkg::btb_update_t       update,
  output btb_pkg::btb_lookup_t       lookup
);

  logic [`BTB_ENTRIES-1:0]                 key_match;
  logic [`BTB_ENTRIES-1:0]                 lookup_match;
  logic [`BTB_ENTRIES-1:0]                 refresh_en;
  logic [`BTB_ENTRIES-1:0]                 replace_en;
  logic [`BTB_ENTRIES*`BTB_ADDR_WIDTH-1:0] targets;

  // picks refresh or replace per update strobe
  btb_alloc u_alloc (
    .clk          (clk),
    .reset        (reset),
    .update_valid (update_valid),
    .key_match    (key_match),
    .refresh_en   (refresh_en),
    .replace_en   (replace_en)
  );

  // fully associative table
  for (genvar i = 0; i < `BTB_ENTRIES; i++) begin : g_entry
    btb_entry u_entry (
      .clk          (clk),
      .reset        (reset),
      .lookup_key   (lookup_key),
      .update       (update),
      .refresh_en   (refresh_en[i]),
      .replace_en   (replace_en[i]),
      .key_match    (key_match[i]),
      .lookup_match (lookup_match[i]),
      .target       (targets[i*`BTB_ADDR_WIDTH +: `BTB_ADDR_WIDTH])
    );
  end

  // hit flag and target mux
  btb_select u_select (
    .lookup_match (lookup_match),
    .targets      (targets),
    .lookup       (lookup)
  );

endmodule

// File: test/tb_btb.sv
`timescale 1ns/100ps

`include "btb_defines.svh"

module tb_btb;

  import btb_pkg::*;

  localparam int clk_period    = 100;
  localparam int open_tries    = 5;
  localparam int reset_timeout = 20;

  logic                       clk;
  logic                       reset;
  logic [`BTB_ADDR_WIDTH-1:0] lookup_key;
  logic                       update_valid;
  btb_update_t                update;
  btb_lookup_t                lookup;

  int                         fd;
  int                         tests_passed;
  int                         tests_failed;
  int                         errors;
  int                         test_errors;
  logic [8*16-1:0]            cur_name;
  logic                       abort;
  logic                       all_ok;

  btb_top u_dut (
    .clk          (clk),
    .reset        (reset),
    .lookup_key   (lookup_key),
    .update_valid (update_valid),
    .update       (update),
    .lookup       (lookup)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  task automatic open_input(output logic failed);
    int tries;
    tries = 0;
    fd = $fopen("test/btb_input.txt", "r");
    while (fd == 0 && tries < open_tries) begin
      @(negedge clk);
      tries++;
      fd = $fopen("test/btb_input.txt", "r");
    end
    failed = (fd == 0);
    if (failed) begin
      $display("could not open test/btb_input.txt");
    end
  endtask

  // two cycles of reset and a wait for the table to read empty
  task automatic apply_reset(output logic failed);
    int waited;
    waited = 0;
    @(negedge clk);
    reset        = 1'b1;
    update_valid = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    while (lookup.hit !== 1'b0 && waited < reset_timeout) begin
      @(negedge clk);
      waited++;
    end
    failed = (lookup.hit !== 1'b0);
    if (failed) begin
      $display("timeout: lookup hit did not clear after reset");
    end
  endtask

  task automatic close_test(input logic [8*16-1:0] name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("PASS %0s", name);
    end else begin
      tests_failed++;
      $display("FAIL %0s (%0d errors)", name, test_errors);
    end
  endtask

  task automatic check_lookup(input logic [8*16-1:0] name, input logic exp_hit,
                              input logic [`BTB_ADDR_WIDTH-1:0] exp_tgt);
    if (lookup.hit !== exp_hit) begin
      $display("ERR %0s hit expected %0b actual %0b", name, exp_hit, lookup.hit);
      test_errors++;
      errors++;
    end
    if (lookup.target !== exp_tgt) begin
      $display("ERR %0s target expected %h actual %h", name, exp_tgt, lookup.target);
      test_errors++;
      errors++;
    end
  endtask

  // one operation per cycle driven on the falling edge
  task automatic run_op(input logic [8*16-1:0] name, input logic [7:0] op,
                        input logic [`BTB_ADDR_WIDTH-1:0] key,
                        input logic [`BTB_ADDR_WIDTH-1:0] tgt, input logic taken,
                        input logic exp_hit, input logic [`BTB_ADDR_WIDTH-1:0] exp_tgt);
    @(negedge clk);
    update_valid  = (op == "U") || (op == "B");
    update.key    = key;
    update.target = tgt;
    update.taken  = taken;
    if (op == "L" || op == "B") begin
      lookup_key = key;
    end
    // sample well before the next rising edge
    #(clk_period/4);
    if (op == "L" || op == "B") begin
      check_lookup(name, exp_hit, exp_tgt);
    end
  endtask

  task automatic run_vectors(output logic failed);
    string                      line;
    int                         nf;
    logic [8*16-1:0]            name_s;
    logic [7:0]                 op_s;
    logic [`BTB_ADDR_WIDTH-1:0] key_v;
    logic [`BTB_ADDR_WIDTH-1:0] tgt_v;
    logic [`BTB_ADDR_WIDTH-1:0] exp_tgt;
    logic                       taken_v;
    logic                       exp_hit;
    failed = 1'b0;
    while (!$feof(fd) && !failed) begin
      line = "";
      nf = $fgets(line, fd);
      // skip blank lines and column notes
      if (line.len() > 1 && line.getc(0) != "#") begin
        nf = $sscanf(line, "%s %s %h %h %h %h %h", name_s, op_s, key_v, tgt_v,
                     taken_v, exp_hit, exp_tgt);
        if (nf != 7) begin
          $display("malformed line in input file: %s", line);
          errors++;
        end else begin
          if (name_s != cur_name) begin
            if (cur_name != '0) begin
              close_test(cur_name);
            end
            cur_name    = name_s;
            test_errors = 0;
          end
          case (op_s)
            "U", "L", "B": run_op(name_s, op_s, key_v, tgt_v, taken_v, exp_hit, exp_tgt);
            "R": apply_reset(failed);
            default: begin
              $display("unknown operation %s in test %0s", op_s, name_s);
              test_errors++;
              errors++;
            end
          endcase
        end
      end
    end
    if (cur_name != '0 && !failed) begin
      close_test(cur_name);
    end
    @(negedge clk);
    update_valid = 1'b0;
  endtask

  initial begin
    reset        = 1'b1;
    lookup_key   = '0;
    update_valid = 1'b0;
    update       = '0;
    tests_passed = 0;
    tests_failed = 0;
    errors       = 0;
    test_errors  = 0;
    cur_name     = '0;
    abort        = 1'b0;

    open_input(abort);
    if (!abort) begin
      apply_reset(abort);
    end
    if (!abort) begin
      run_vectors(abort);
      $fclose(fd);
    end

    all_ok = !abort && (errors == 0) && (tests_failed == 0) && (tests_passed > 0);
    $display("tests: %0d passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (all_ok) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: btb_top.f
+incdir+rtl
rtl/btb_pkg.sv
rtl/btb_entry.sv
rtl/btb_alloc.sv
rtl/btb_select.sv
rtl/btb_top.sv
test/tb_btb.sv

// File: Makefile
# build and run the BTB testbench with Verilator

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing -j 0 -f btb_top.f --top-module tb_btb -Mdir obj_dir
	./obj_dir/Vtb_btb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ALL TESTS PASSED" $(LOG); then \
	  echo "test: pass"; \
	else \
	  echo "test: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: test/btb_input.txt
# name op key target taken exp_hit exp_target, all values in hex
# op U update, L lookup, B update and lookup in one cycle, R reset
reset_miss      L 0000 0000 0 0 0000
reset_miss      L 1234 0000 0 0 0000
reset_miss      L ffff 0000 0 0 0000
alloc_taken     U 0100 2000 1 0 0000
alloc_taken     L 0100 0000 0 1 2000
alloc_not_taken U 0200 3000 0 0 0000
alloc_not_taken L 0200 0000 0 0 0000
counter_step    U 0200 3100 1 0 0000
counter_step    L 0200 0000 0 0 0000
counter_step    U 0200 3200 1 0 0000
counter_step    L 0200 0000 0 1 3200
hysteresis      U 0100 2100 0 0 0000
hysteresis      L 0100 0000 0 1 2000
hysteresis      U 0100 2200 0 0 0000
hysteresis      L 0100 0000 0 0 0000
hysteresis      U 0100 2300 1 0 0000
hysteresis      L 0100 0000 0 1 2300
round_robin     R 0000 0000 0 0 0000
round_robin     U a000 b000 1 0 0000
round_robin     U a001 b001 1 0 0000
round_robin     U a002 b002 1 0 0000
round_robin     U a003 b003 1 0 0000
round_robin     U a001 b101 1 0 0000
round_robin     U a004 b004 1 0 0000
round_robin     U a005 b005 1 0 0000
round_robin     U a006 b006 1 0 0000
round_robin     U a007 b007 1 0 0000
round_robin     U a008 b008 1 0 0000
round_robin     L a000 0000 0 0 0000
round_robin     L a001 0000 0 1 b101
round_robin     L a002 0000 0 1 b002
round_robin     L a003 0000 0 1 b003
round_robin     L a004 0000 0 1 b004
round_robin     L a005 0000 0 1 b005
round_robin     L a006 0000 0 1 b006
round_robin     L a007 0000 0 1 b007
round_robin     L a008 0000 0 1 b008
same_cycle      B c000 d000 1 0 0000
same_cycle      L c000 0000 0 1 d000
same_cycle      U a004 e004 0 0 0000
same_cycle      B a004 e104 0 1 b004
same_cycle      L a004 0000 0 0 0000
